// File: obj_defines.svh
`ifndef OBJ_DEFINES_SVH
`define OBJ_DEFINES_SVH

// Object table geometry. Each entry is four 16-bit words.
`define OBJ_COUNT   256
`define OBJ_WORDS   4
`define OBJ_RAM_AW  10

// Graphics ROM is addressed in 32-bit words.
`define ROM_AW      17

// Raw x values in [LO, HI) are never drawn.
`define OBJ_SKIP_LO 256
`define OBJ_SKIP_HI 496

// Horizontal offset between the table x and the line buffer.
`define OBJ_XOFF    8

`endif

// File: obj_dma.sv
`timescale 1ns/10ps
`include "obj_defines.svh"

module obj_dma import obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    input  logic      start,
    output obj_addr_t addr,
    output logic      we
);

    localparam obj_addr_t LAST_ADDR = obj_addr_t'(`OBJ_COUNT * `OBJ_WORDS - 1);

    // Start is remembered until the next pixel enable.
    logic armed;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
            we    <= 1'b0;
            addr  <= '0;
        end else if (start) begin
            armed <= 1'b1;
        end else if (pxl_cen) begin
            if (armed) begin
                armed <= 1'b0;
                we    <= 1'b1;
                addr  <= '0;
            end else if (we) begin
                // One word per pixel enable until the whole buffer is copied.
                if (addr == LAST_ADDR) begin
                    we <= 1'b0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end
        end
    end

endmodule

// File: obj_draw.sv
`timescale 1ns/10ps

module obj_draw import video_pkg::*, obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      draw,
    input  draw_req_t req,
    input  logic      rom_ok,
    input  rom_word_t rom_data,
    output logic      busy,
    output logic      rom_cs,
    output rom_addr_t rom_addr,
    output logic      buf_we,
    output buf_wr_t   buf_wr
);

    draw_state_t st;
    draw_req_t   cur;
    logic        half;
    logic [3:0]  cnt;
    logic [63:0] row;
    rom_word_t   rom_mirror;
    hpos_t       xcur;
    logic [3:0]  colour;

    // Reverses the pixel order inside one ROM word.
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            rom_mirror[4*k +: 4] = rom_data[4*(7-k) +: 4];
        end
    end

    assign busy     = st != IDLE;
    assign rom_cs   = st == FETCH;
    assign rom_addr = {cur.code, cur.ysub ^ {4{cur.vflip}}, half};

    assign colour = row[3:0];
    assign xcur   = cur.xpos + hpos_t'(cnt);
    assign buf_we = (st == PAINT) && (colour != 4'd0) && !xcur[8];
    assign buf_wr = '{addr: xcur[7:0], pixel: {cur.pal, colour}};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            st   <= IDLE;
            half <= 1'b0;
            cnt  <= '0;
        end else begin
            case (st)
                IDLE: begin
                    if (draw) begin
                        st   <= FETCH;
                        half <= 1'b0;
                    end
                end
                FETCH: begin
                    // The ROM may take its time; the address holds meanwhile.
                    if (rom_ok) begin
                        half <= 1'b1;
                        if (half) begin
                            st  <= PAINT;
                            cnt <= '0;
                        end
                    end
                end
                default: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15) begin
                        st <= IDLE;
                    end
                end
            endcase
        end
    end

    // With hflip the left ROM half lands in the right screen half, mirrored.
    always_ff @(posedge clk) begin
        if (st == IDLE && draw) begin
            cur <= req;
        end
        if (st == FETCH && rom_ok) begin
            if (half ^ cur.hflip) begin
                row[63:32] <= cur.hflip ? rom_mirror : rom_data;
            end else begin
                row[31:0] <= cur.hflip ? rom_mirror : rom_data;
            end
        end else if (st == PAINT) begin
            row <= row >> 4;
        end
    end

endmodule

// File: obj_engine.sv
`timescale 1ns/10ps

module obj_engine import video_pkg::*, obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl_cen,
    input  logic      hs,
    input  hpos_t     hdump,
    input  vpos_t     vrender,
    input  logic      dma_start,
    input  obj_word_t ram_data,
    input  logic      rom_ok,
    input  rom_word_t rom_data,
    output obj_addr_t dma_addr,
    output logic      dma_we,
    output obj_addr_t ram_addr,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    output pxl_t      pxl
);

    obj_addr_t scan_addr;
    logic      draw;
    logic      busy;
    draw_req_t req;
    logic      buf_we;
    buf_wr_t   buf_wr;

    // The copy owns the table port while it runs and the scanner waits.
    assign ram_addr = dma_we ? dma_addr : scan_addr;

    obj_dma obj_dma_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .start    (dma_start),
        .addr     (dma_addr),
        .we       (dma_we)
    );

    obj_scan obj_scan_inst (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .vrender  (vrender),
        .ram_data (ram_data),
        .dma_we   (dma_we),
        .busy     (busy),
        .ram_addr (scan_addr),
        .draw     (draw),
        .req      (req)
    );

    obj_draw obj_draw_inst (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw),
        .req      (req),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .busy     (busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .buf_we   (buf_we),
        .buf_wr   (buf_wr)
    );

    obj_line_buffer obj_line_buffer_inst (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .hdump    (hdump),
        .buf_we   (buf_we),
        .buf_wr   (buf_wr),
        .pxl      (pxl)
    );

endmodule

// File: obj_engine_tb.sv
`timescale 1ns/10ps
`include "obj_defines.svh"

module obj_engine_tb import video_pkg::*, obj_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      pxl_cen;
    logic      hs;
    hpos_t     hdump;
    vpos_t     vrender;
    logic      dma_start;
    obj_word_t ram_data;
    logic      rom_ok;
    rom_word_t rom_data;
    obj_addr_t dma_addr;
    logic      dma_we;
    obj_addr_t ram_addr;
    rom_addr_t rom_addr;
    logic      rom_cs;
    pxl_t      pxl;

    obj_word_t obj_ram [`OBJ_COUNT * `OBJ_WORDS];
    int        rom_wait;
    rom_addr_t fetch_addr;
    logic      fetch_waiting;
    pxl_t      pred  [256];    // line being drawn now
    pxl_t      shown [256];    // line on display now

    obj_engine obj_engine_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        pxl_cen <= !pxl_cen;
    end

    // Object RAM is read combinationally.
    assign ram_data = obj_ram[ram_addr];

    //////////////////////////////////////////////////
    // Graphics ROM model

    function automatic rom_word_t rom_word(rom_addr_t a);
        logic [31:0] h;
        rom_word_t   w;
        h = 32'(a) * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        // Small values become colour 0, so about a quarter of the pixels are transparent.
        for (int k = 0; k < 8; k++) begin
            w[4*k +: 4] = (h[4*k +: 4] < 4'd4) ? 4'd0 : h[4*k +: 4];
        end
        return w;
    endfunction

    // Each fetch is answered after 0 to 3 extra cycles, and ok drops after it is taken.
    always @(posedge clk) begin
        if (rom_cs && rom_ok) begin
            rom_ok   <= 1'b0;
            rom_wait <= int'($urandom_range(3, 0));
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // A fetch that has not been answered yet keeps its address.
    always @(posedge clk) begin
        if (fetch_waiting && rom_cs) begin
            assert (rom_addr == fetch_addr) else stop_run($sformatf(
                "error at time %0t: rom_addr is %h, expected %h",
                $time, rom_addr, fetch_addr));
        end
        fetch_waiting <= rom_cs && !rom_ok;
        fetch_addr    <= rom_addr;
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    // Returns on a clock edge at which the DUT saw pxl_cen high.
    task automatic wait_pixel_enable();
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
            assert (guard < 4) else stop_run("pxl_cen stopped toggling");
        end while (!pxl_cen);
    endtask

    task automatic clear_table();
        foreach (obj_ram[i]) begin
            obj_ram[i] <= '0;
        end
    endtask

    task automatic put_obj(input int idx, input logic en, input obj_word_t attr,
                           input logic [8:0] ry, input logic [8:0] rx,
                           input obj_word_t code_word);
        obj_ram[`OBJ_WORDS * idx]     <= {en, 6'd0, ry};
        obj_ram[`OBJ_WORDS * idx + 1] <= attr;
        obj_ram[`OBJ_WORDS * idx + 2] <= {7'd0, rx};
        obj_ram[`OBJ_WORDS * idx + 3] <= code_word;
    endtask

    // Builds the expected line from the table, the later entries painted last.
    function automatic void predict_line(vpos_t v);
        obj_word_t  w0;
        obj_word_t  w1;
        obj_word_t  w2;
        obj_word_t  w3;
        vpos_t      d;
        logic       hflip;
        logic       vflip;
        ysub_t      row;
        obj_code_t  code;
        logic [8:0] x0;
        hpos_t      x;
        int         src;
        rom_word_t  w;
        logic [3:0] col;
        foreach (pred[i]) begin
            pred[i] = '0;
        end
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            w0 = obj_ram[`OBJ_WORDS * i];
            w1 = obj_ram[`OBJ_WORDS * i + 1];
            w2 = obj_ram[`OBJ_WORDS * i + 2];
            w3 = obj_ram[`OBJ_WORDS * i + 3];
            d  = vpos_t'(9'h100 - w0[8:0]) - v;
            if (!w0[15] || !w1[0]) continue;
            if (d >= (w1[4] ? 9'd32 : 9'd16)) continue;
            if (w2[8:0] >= 9'(`OBJ_SKIP_LO) && w2[8:0] < 9'(`OBJ_SKIP_HI)) continue;
            hflip = !w1[2];
            vflip = !w1[1];
            row   = d[3:0] ^ {4{vflip}};
            code  = w3[11:0];
            if (w1[4]) begin
                code[0] = vflip ^ d[4];
            end
            x0 = 9'h100 - w2[8:0] - 9'(`OBJ_XOFF);
            for (int p = 0; p < 16; p++) begin
                src = hflip ? 15 - p : p;
                w   = rom_word({code, row, src >= 8});
                col = w[4*(src % 8) +: 4];
                x   = x0 + 9'(p);
                if (col != 4'd0 && !x[8]) begin
                    pred[x[7:0]] = {w3[15:12], col};
                end
            end
        end
    endfunction

    // Copy check. The scanner must hold its place while dma_we is high.
    task automatic check_dma();
        int n;
        int guard;
        n     = 0;
        guard = 0;
        dma_start <= 1'b1;
        @(posedge clk);
        dma_start <= 1'b0;
        do begin
            wait_pixel_enable();
            guard++;
            assert (guard < 8) else stop_run("dma_we did not rise after dma_start");
        end while (!dma_we);
        while (dma_we) begin
            assert (n < 1024) else stop_run("dma_we stayed high after address 1023");
            assert (dma_addr == obj_addr_t'(n)) else stop_run($sformatf(
                "error at time %0t: dma_addr is %0d, expected %0d", $time, dma_addr, n));
            assert (ram_addr == dma_addr) else stop_run($sformatf(
                "error at time %0t: ram_addr is %0d, expected %0d", $time, ram_addr, dma_addr));
            n++;
            wait_pixel_enable();
        end
        assert (n == 1024) else stop_run($sformatf(
            "error at time %0t: dma_we count is %0d, expected 1024", $time, n));
    endtask

    // Runs one video line with hs and then hdump 0 to 383, and checks the line drawn before.
    task automatic run_line(input vpos_t v, input logic check, input logic with_dma);
        pxl_t want;
        wait_pixel_enable();
        shown = pred;
        predict_line(v);
        hs      <= 1'b1;
        vrender <= v;
        @(posedge clk);
        hs <= 1'b0;
        if (with_dma) begin
            check_dma();
        end
        for (int h = 0; h <= 384; h++) begin
            if (h < 384) begin
                hdump <= hpos_t'(h);
            end
            wait_pixel_enable();
            // The value seen here was loaded at the enable for hdump h - 1.
            if (check && h > 0) begin
                want = (h <= 256) ? shown[h-1] : '0;
                assert (pxl === want) else stop_run($sformatf(
                    "error at time %0t: pxl at hdump %0d is %h, expected %h",
                    $time, h - 1, pxl, want));
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic reset_and_dma();
        assert (dma_we == 1'b0) else stop_run($sformatf(
            "error at time %0t: dma_we is %b, expected 0", $time, dma_we));
        assert (rom_cs == 1'b0) else stop_run($sformatf(
            "error at time %0t: rom_cs is %b, expected 0", $time, rom_cs));
        assert (pxl == '0) else stop_run($sformatf(
            "error at time %0t: pxl is %h, expected 00", $time, pxl));
        clear_table();
        // Two empty lines sweep both banks clean.
        run_line(9'd0, 1'b0, 1'b0);
        run_line(9'd1, 1'b0, 1'b0);
        put_obj(20, 1'b1, 16'h0007, 9'd156, 9'd48, 16'h5123);
        run_line(9'd96, 1'b1, 1'b1);
        run_line(9'd97, 1'b1, 1'b0);
    endtask

    task automatic single_object();
        clear_table();
        put_obj(5, 1'b1, 16'h0007, 9'd156, 9'd100, 16'ha2c4);
        for (int v = 83; v <= 102; v++) begin
            run_line(vpos_t'(v), 1'b1, 1'b0);
        end
    endtask

    task automatic flips_and_tall();
        clear_table();
        put_obj(3, 1'b1, 16'h0003, 9'd216, 9'd20, 16'h3456);
        put_obj(7, 1'b1, 16'h0005, 9'd216, 9'd120, 16'h7789);
        put_obj(9, 1'b1, 16'h0017, 9'd216, 9'd200, 16'h9abc);
        put_obj(12, 1'b1, 16'h0015, 9'd206, 9'd230, 16'hc0f1);
        for (int v = 7; v <= 52; v++) begin
            run_line(vpos_t'(v), 1'b1, 1'b0);
        end
    endtask

    task automatic skip_rules();
        clear_table();
        put_obj(1, 1'b0, 16'h0007, 9'd116, 9'd60, 16'h1111);
        put_obj(2, 1'b1, 16'h0006, 9'd116, 9'd90, 16'h2222);
        put_obj(4, 1'b1, 16'h0007, 9'd116, 9'd256, 16'h3333);
        put_obj(6, 1'b1, 16'h0007, 9'd116, 9'd495, 16'h4444);
        put_obj(8, 1'b1, 16'h0007, 9'd116, 9'd300, 16'h5555);
        put_obj(10, 1'b1, 16'h0007, 9'd116, 9'd2, 16'h6666);
        put_obj(11, 1'b1, 16'h0007, 9'd116, 9'd496, 16'h7777);
        put_obj(13, 1'b1, 16'h0007, 9'd116, 9'd30, 16'h8888);
        for (int v = 123; v <= 142; v++) begin
            run_line(vpos_t'(v), 1'b1, 1'b0);
        end
    endtask

    task automatic overlap_priority();
        int         top;
        int         idx;
        logic [2:0] r;
        for (int s = 0; s < 4; s++) begin
            clear_table();
            top = int'($urandom_range(205, 200));
            idx = 0;
            for (int k = 0; k < 6; k++) begin
                idx = idx + int'($urandom_range(40, 1));
                r   = 3'($urandom);
                put_obj(idx, 1'b1, {11'd0, r[2], 1'b0, r[1], r[0], 1'b1},
                        9'(256 - top), 9'($urandom_range(90, 40)), 16'($urandom));
            end
            for (int v = top - 32; v <= top + 1; v++) begin
                run_line(vpos_t'(v), 1'b1, 1'b0);
            end
        end
    endtask

    // The bank that showed the object must come back empty.
    task automatic line_clearing();
        clear_table();
        put_obj(30, 1'b1, 16'h0007, 9'd56, 9'd10, 16'h6e21);
        run_line(9'd200, 1'b1, 1'b0);
        clear_table();
        for (int n = 0; n < 4; n++) begin
            run_line(9'd200, 1'b1, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hdd9e_f36f));
        rst           = 1'b1;
        pxl_cen       = 1'b0;
        hs            = 1'b0;
        hdump         = 9'd383;
        vrender       = '0;
        dma_start     = 1'b0;
        rom_ok        = 1'b0;
        rom_data      = '0;
        rom_wait      = 0;
        fetch_waiting = 1'b0;
        foreach (pred[i]) begin
            pred[i] = '0;
        end
        foreach (obj_ram[i]) begin
            obj_ram[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        reset_and_dma();
        single_object();
        flips_and_tall();
        skip_rules();
        overlap_priority();
        line_clearing();

        $display("No errors");
        $finish;
    end

endmodule

// File: obj_line_buffer.sv
`timescale 1ns/10ps

module obj_line_buffer import video_pkg::*, obj_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    pxl_cen,
    input  logic    hs,
    input  hpos_t   hdump,
    input  logic    buf_we,
    input  buf_wr_t buf_wr,
    output pxl_t    pxl
);

    logic       bank;       // bank being drawn, the other one is shown
    logic       hs_l;
    logic       clr;
    logic [7:0] rd_addr;
    pxl_t       rd_data [2];

    assign rd_addr = hdump[7:0];
    assign clr     = pxl_cen && !hdump[8];

    // Each bank has one write port. It takes drawer writes while the bank is
    // being drawn and clears behind the read while it is on display.
    for (genvar b = 0; b < 2; b++) begin : g_bank
        pxl_t mem [256];

        always_ff @(posedge clk) begin
            if (bank == 1'(b)) begin
                if (buf_we) begin
                    mem[buf_wr.addr] <= buf_wr.pixel;
                end
            end else if (clr) begin
                mem[rd_addr] <= '0;
            end
        end

        assign rd_data[b] = mem[rd_addr];
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            hs_l <= 1'b0;
            pxl  <= '0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) begin
                bank <= ~bank;
            end
            if (pxl_cen) begin
                pxl <= hdump[8] ? '0 : rd_data[~bank];
            end
        end
    end

endmodule

// File: obj_pkg.sv
`include "obj_defines.svh"

package obj_pkg;
    import video_pkg::*;

    typedef logic [`OBJ_RAM_AW-1:0] obj_addr_t;
    typedef logic [15:0]            obj_word_t;
    typedef logic [11:0]            obj_code_t;
    typedef logic [3:0]             obj_pal_t;
    typedef logic [3:0]             ysub_t;
    typedef logic [`ROM_AW-1:0]     rom_addr_t;

    // Eight 4-bit pixels, leftmost one in the low nibble.
    typedef logic [31:0] rom_word_t;

    // One object row to be drawn.
    typedef struct packed {
        obj_code_t code;
        obj_pal_t  pal;
        hpos_t     xpos;
        ysub_t     ysub;
        logic      hflip;
        logic      vflip;
    } draw_req_t;

    // One pixel written into the line buffer.
    typedef struct packed {
        logic [7:0] addr;
        pxl_t       pixel;
    } buf_wr_t;

    typedef enum logic [1:0] {
        WORD_Y,
        WORD_ATTR,
        WORD_X,
        WORD_CODE
    } scan_state_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        PAINT
    } draw_state_t;

endpackage

// File: obj_scan.sv
`timescale 1ns/10ps
`include "obj_defines.svh"

module obj_scan import video_pkg::*, obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      hs,
    input  vpos_t     vrender,
    input  obj_word_t ram_data,
    input  logic      dma_we,
    input  logic      busy,
    output obj_addr_t ram_addr,
    output logic      draw,
    output draw_req_t req
);

    localparam int               CNT_W    = $clog2(`OBJ_COUNT);
    localparam logic [CNT_W-1:0] LAST_OBJ = CNT_W'(`OBJ_COUNT - 1);

    logic [CNT_W-1:0] obj_cnt;
    scan_state_t      st;
    logic             done;
    logic             step;
    logic             adv;
    logic             match;
    logic             in_skip;
    vpos_t            ytop;
    vpos_t            ydiff;
    logic             tall;
    logic             hflip;
    logic             vflip;
    hpos_t            xdraw;
    obj_code_t        code;

    //////////////////////////////////////////////////
    // Entry tests

    assign ram_addr = {obj_cnt, st};
    assign step     = !hs && !done && !dma_we;
    assign ydiff    = ytop - vrender;

    // The height bit is tested live on the attribute word.
    assign match   = ram_data[4] ? (ydiff[8:5] == '0) : (ydiff[8:4] == '0);
    assign in_skip = (ram_data[8:0] >= 9'(`OBJ_SKIP_LO)) &&
                     (ram_data[8:0] <  9'(`OBJ_SKIP_HI));

    // Tall objects are two stacked tiles, picked by bit 0 of the code.
    always_comb begin
        code = ram_data[11:0];
        if (tall) begin
            code[0] = vflip ^ ydiff[4];
        end
    end

    // An entry ends early as soon as one of its words rules it out.
    always_comb begin
        case (st)
            WORD_Y:    adv = !ram_data[15];
            WORD_ATTR: adv = !ram_data[0] || !match;
            WORD_X:    adv = in_skip;
            default:   adv = !busy;
        endcase
    end

    //////////////////////////////////////////////////
    // Table walk

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            obj_cnt <= '0;
            st      <= WORD_Y;
            done    <= 1'b0;
            draw    <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (hs) begin
                obj_cnt <= '0;
                st      <= WORD_Y;
                done    <= 1'b0;
            end else if (step) begin
                if (adv) begin
                    obj_cnt <= obj_cnt + 1'b1;
                    st      <= WORD_Y;
                    done    <= obj_cnt == LAST_OBJ;
                    draw    <= st == WORD_CODE;
                end else begin
                    case (st)
                        WORD_Y:    st <= WORD_ATTR;
                        WORD_ATTR: st <= WORD_X;
                        default:   st <= WORD_CODE;
                    endcase
                end
            end
        end
    end

    // Latched fields of the entry being scanned.
    always_ff @(posedge clk) begin
        if (step) begin
            case (st)
                WORD_Y: begin
                    ytop <= 9'h100 - ram_data[8:0];
                end
                WORD_ATTR: begin
                    tall  <= ram_data[4];
                    hflip <= ~ram_data[2];
                    vflip <= ~ram_data[1];
                end
                WORD_X: begin
                    xdraw <= 9'h100 - ram_data[8:0] - 9'(`OBJ_XOFF);
                end
                default: begin
                    if (!busy) begin
                        req <= '{code:  code,
                                 pal:   ram_data[15:12],
                                 xpos:  xdraw,
                                 ysub:  ydiff[3:0],
                                 hflip: hflip,
                                 vflip: vflip};
                    end
                end
            endcase
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the object engine testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_engine_tb -f sim.f -o obj_engine_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/obj_engine_sim; then
    echo "Simulation run failed"
    exit 1
fi

exit 0

// File: sim.f
+incdir+.
video_pkg.sv
obj_pkg.sv
obj_dma.sv
obj_scan.sv
obj_draw.sv
obj_line_buffer.sv
obj_engine.sv
obj_engine_tb.sv

// File: video_pkg.sv
package video_pkg;

    // Horizontal dump position. The visible part is 0 to 255.
    typedef logic [8:0] hpos_t;

    // Line being rendered.
    typedef logic [8:0] vpos_t;

    // Palette in the upper nibble, colour in the lower one.
    // Colour 0 is transparent.
    typedef logic [7:0] pxl_t;

endpackage
